// ==== rtl/busPkg.sv ====
/* Shared bus definitions for the three-master AHB-lite subsystem.
   Widths, arbiter states, transfer sizes and master select codes. */

package busPkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Master select codes on addrSel and dataSel
    localparam logic [1:0] SEL_T = 2'd0;
    localparam logic [1:0] SEL_M = 2'd1;
    localparam logic [1:0] SEL_F = 2'd2;

    // Arbitration sequence states
    // sSingle picks by priority, the rest finish a locked group
    typedef enum logic [2:0] {
        sSingle,
        sTmf2,
        sTmf3,
        sMf,
        sTm,
        sTf
    } arbState;

    // Transfer size, AHB HSIZE encoding
    typedef enum logic [2:0] {
        sizeByte = 3'b000,
        sizeHalf = 3'b001,
        sizeWord = 3'b010
    } hSize;

endpackage

// ==== rtl/waitTimer.sv ====
/* Wait-state down-counter for the memory slave.
   Holds done low for WAIT_STATES cycles after each accepted address phase. */

`timescale 1ns/1ns

module waitTimer #(
    parameter int WAIT_STATES = 1
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic hold,
    output logic done
);

    // At least one bit, even with zero wait states
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            // Load at address acceptance
            count <= CNT_W'(WAIT_STATES);
        end else if (hold && !done) begin
            // Count down through the data phase
            count <= count - CNT_W'(1);
        end
    end

    // Zero wait states keeps this high all the time
    assign done = (count == '0);

endmodule

// ==== rtl/arbController.sv ====
/* Bus arbiter FSM for the walker, data cache and fetch masters.
   Fixed priority T, M, F with locked multi-request sequences and ready pulses. */

`timescale 1ns/1ns

module arbController (
    input  logic       clk,
    input  logic       reset,
    input  logic       requestT,
    input  logic       requestM,
    input  logic       requestF,
    input  logic       hready,
    output logic [1:0] addrSel,
    output logic       selValid,
    output logic [1:0] dataSel,
    output logic       dataValid,
    output logic       hreadyT,
    output logic       hreadyM,
    output logic       hreadyF
);
    import busPkg::*;

    arbState state;
    arbState nextState;

    // Master has a transfer in its data phase
    logic pendT;
    logic pendM;
    logic pendF;

    // Requests not yet issued
    logic reqT;
    logic reqM;
    logic reqF;

    // Address phase selection
    logic selT;
    logic selM;
    logic selF;
    logic accept;

    // Mask masters already waiting on their own ready
    assign reqT = requestT & ~pendT;
    assign reqM = requestM & ~pendM;
    assign reqF = requestF & ~pendF;

    // Selection per state
    always_comb begin
        selT = 1'b0;
        selM = 1'b0;
        selF = 1'b0;
        case (state)
            sSingle: begin
                selT = reqT;
                selM = ~reqT & reqM;
                selF = ~reqT & ~reqM & reqF;
            end
            // Second member of TMF or TM
            sTmf2, sTm: selM = 1'b1;
            // Last member of any group ending in F
            sTmf3, sMf, sTf: selF = 1'b1;
            default: selT = 1'b0;
        endcase
    end

    assign selValid = selT | selM | selF;
    assign accept = hready & selValid;

    always_comb begin
        if (selM) begin
            addrSel = SEL_M;
        end else if (selF) begin
            addrSel = SEL_F;
        end else begin
            addrSel = SEL_T;
        end
    end

    // Next state, frozen while the slave stalls
    always_comb begin
        nextState = state;
        if (hready) begin
            case (state)
                sSingle: begin
                    // Lock the group seen at this edge
                    if (reqT & reqM & reqF) begin
                        nextState = sTmf2;
                    end else if (reqT & reqM) begin
                        nextState = sTm;
                    end else if (reqT & reqF) begin
                        nextState = sTf;
                    end else if (reqM & reqF) begin
                        nextState = sMf;
                    end
                end
                sTmf2: nextState = sTmf3;
                default: nextState = sSingle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sSingle;
        end else begin
            state <= nextState;
        end
    end

    // Data phase owner follows the accepted address phase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dataSel   <= SEL_T;
            dataValid <= 1'b0;
        end else if (hready) begin
            dataSel   <= addrSel;
            dataValid <= selValid;
        end
    end

    // Set on issue, cleared by own ready pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pendT <= 1'b0;
            pendM <= 1'b0;
            pendF <= 1'b0;
        end else begin
            pendT <= (pendT & ~hreadyT) | (accept & selT);
            pendM <= (pendM & ~hreadyM) | (accept & selM);
            pendF <= (pendF & ~hreadyF) | (accept & selF);
        end
    end

    // One ready pulse to the owner at data phase end
    assign hreadyT = dataValid & hready & (dataSel == SEL_T);
    assign hreadyM = dataValid & hready & (dataSel == SEL_M);
    assign hreadyF = dataValid & hready & (dataSel == SEL_F);

endmodule

// ==== rtl/busDatapath.sv ====
/* Bus datapath between the three masters and the memory slave.
   Address and control mux, write data gating and read data return. */

`timescale 1ns/1ns

module busDatapath (
    input  logic [busPkg::ADDR_W-1:0] addrT,
    input  logic [busPkg::ADDR_W-1:0] addrM,
    input  logic [busPkg::ADDR_W-1:0] addrF,
    input  logic                      writeM,
    input  busPkg::hSize              sizeM,
    input  logic [busPkg::DATA_W-1:0] wdataM,
    input  logic [1:0]                addrSel,
    input  logic                      selValid,
    input  logic [1:0]                dataSel,
    input  logic                      dataValid,
    input  logic [busPkg::DATA_W-1:0] hrdata,
    output logic [busPkg::ADDR_W-1:0] haddr,
    output logic                      hwrite,
    output busPkg::hSize              hsize,
    output logic                      htransValid,
    output logic [busPkg::DATA_W-1:0] hwdata,
    output logic [busPkg::DATA_W-1:0] rdata
);
    import busPkg::*;

    logic addrIsM;
    logic dataIsM;

    // M owns the current address phase
    assign addrIsM = selValid && (addrSel == SEL_M);
    // M owns the current data phase
    assign dataIsM = dataValid && (dataSel == SEL_M);

    // Address mux
    always_comb begin
        case (addrSel)
            SEL_M:   haddr = addrM;
            SEL_F:   haddr = addrF;
            default: haddr = addrT;
        endcase
    end

    // T and F only read whole words
    assign hwrite = addrIsM & writeM;

    always_comb begin
        if (addrIsM) begin
            hsize = sizeM;
        end else begin
            hsize = sizeWord;
        end
    end

    assign htransValid = selValid;

    // Write data only from M, zero otherwise
    assign hwdata = dataIsM ? wdataM : '0;

    // Read data shared by all masters
    assign rdata = hrdata;

endmodule

// ==== rtl/memSlave.sv ====
/* Word-addressed memory slave with byte-lane writes and wait states.
   Captures the address phase and completes after the wait timer expires. */

`timescale 1ns/1ns

module memSlave #(
    parameter int WAIT_STATES = 1,
    parameter int MEM_WORDS   = 256
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [busPkg::ADDR_W-1:0] haddr,
    input  logic                      hwrite,
    input  busPkg::hSize              hsize,
    input  logic                      htransValid,
    input  logic [busPkg::DATA_W-1:0] hwdata,
    output logic                      hready,
    output logic [busPkg::DATA_W-1:0] hrdata
);
    import busPkg::*;

    localparam int LANES = DATA_W / 8;
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    // Captured address phase
    logic [ADDR_W-1:0] addrQ;
    logic              writeQ;
    hSize              sizeQ;
    logic              activeQ;

    logic              accept;
    logic [IDX_W-1:0]  wordIdx;
    logic [LANES-1:0]  laneEn;

    assign accept = htransValid & hready;

    // Data phase in flight
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            activeQ <= 1'b0;
        end else if (hready) begin
            activeQ <= htransValid;
        end
    end

    // Only loaded on acceptance, so a stall keeps them
    always_ff @(posedge clk) begin
        if (accept) begin
            addrQ  <= haddr;
            writeQ <= hwrite;
            sizeQ  <= hsize;
        end
    end

    waitTimer #(
        .WAIT_STATES(WAIT_STATES)
    ) u_waitTimer (
        .clk  (clk),
        .reset(reset),
        .start(accept),
        .hold (activeQ),
        .done (hready)
    );

    // Word index wraps over the array
    assign wordIdx = IDX_W'(addrQ[ADDR_W-1:2] % MEM_WORDS);

    // Byte lanes from size and low address bits
    always_comb begin
        case (sizeQ)
            sizeByte: laneEn = LANES'(1) << addrQ[1:0];
            sizeHalf: laneEn = LANES'(3) << {addrQ[1], 1'b0};
            default:  laneEn = '1;
        endcase
    end

    // Write lands on the last edge of the data phase
    always_ff @(posedge clk) begin
        if (activeQ && hready && writeQ) begin
            for (int i = 0; i < LANES; i++) begin
                if (laneEn[i]) begin
                    mem[wordIdx][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // Read word, sampled by the master on its ready pulse
    assign hrdata = (activeQ && !writeQ) ? mem[wordIdx] : '0;

endmodule

// ==== rtl/busTop.sv ====
/* Shared bus subsystem top for the walker, data cache and fetch masters.
   Connects the arbiter, the bus datapath and the memory slave. */

`timescale 1ns/1ns

module busTop #(
    parameter int WAIT_STATES = 1,
    parameter int MEM_WORDS   = 256
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      requestT,
    input  logic                      requestM,
    input  logic                      requestF,
    input  logic [busPkg::ADDR_W-1:0] addrT,
    input  logic [busPkg::ADDR_W-1:0] addrM,
    input  logic [busPkg::ADDR_W-1:0] addrF,
    input  logic                      writeM,
    input  busPkg::hSize              sizeM,
    input  logic [busPkg::DATA_W-1:0] wdataM,
    output logic                      hreadyT,
    output logic                      hreadyM,
    output logic                      hreadyF,
    output logic [busPkg::DATA_W-1:0] rdata
);
    import busPkg::*;

    // Arbiter to datapath
    logic [1:0]        addrSel;
    logic              selValid;
    logic [1:0]        dataSel;
    logic              dataValid;

    // Slave side of the bus
    logic [ADDR_W-1:0] haddr;
    logic              hwrite;
    hSize              hsize;
    logic              htransValid;
    logic [DATA_W-1:0] hwdata;
    logic              hready;
    logic [DATA_W-1:0] hrdata;

    arbController u_arbController (
        .clk      (clk),
        .reset    (reset),
        .requestT (requestT),
        .requestM (requestM),
        .requestF (requestF),
        .hready   (hready),
        .addrSel  (addrSel),
        .selValid (selValid),
        .dataSel  (dataSel),
        .dataValid(dataValid),
        .hreadyT  (hreadyT),
        .hreadyM  (hreadyM),
        .hreadyF  (hreadyF)
    );

    busDatapath u_busDatapath (
        .addrT      (addrT),
        .addrM      (addrM),
        .addrF      (addrF),
        .writeM     (writeM),
        .sizeM      (sizeM),
        .wdataM     (wdataM),
        .addrSel    (addrSel),
        .selValid   (selValid),
        .dataSel    (dataSel),
        .dataValid  (dataValid),
        .hrdata     (hrdata),
        .haddr      (haddr),
        .hwrite     (hwrite),
        .hsize      (hsize),
        .htransValid(htransValid),
        .hwdata     (hwdata),
        .rdata      (rdata)
    );

    memSlave #(
        .WAIT_STATES(WAIT_STATES),
        .MEM_WORDS  (MEM_WORDS)
    ) u_memSlave (
        .clk        (clk),
        .reset      (reset),
        .haddr      (haddr),
        .hwrite     (hwrite),
        .hsize      (hsize),
        .htransValid(htransValid),
        .hwdata     (hwdata),
        .hready     (hready),
        .hrdata     (hrdata)
    );

endmodule

// ==== bench/bus_assert.sv ====
/* Bound checks on the arbiter's pending masks and ready pulses.
   One transfer in its data phase at a time, pulses only for its owner. */

`timescale 1ns/1ns

module busAssert (
    input logic clk,
    input logic reset,
    input logic hready,
    input logic hreadyT,
    input logic hreadyM,
    input logic hreadyF,
    input logic pendT,
    input logic pendM,
    input logic pendF
);

    // One master in its data phase at a time
    aOneOwner: assert property (@(posedge clk) disable iff (reset)
        $onehot0({pendT, pendM, pendF}))
        else $error("more than one master in its data phase");

    // Pulse only for a master with a transfer in flight
    aPending: assert property (@(posedge clk) disable iff (reset)
        (hreadyT |-> pendT) and (hreadyM |-> pendM) and (hreadyF |-> pendF))
        else $error("ready pulse for a master without a pending transfer");

    // Slave stalls only inside a data phase with one owner
    aStall: assert property (@(posedge clk) disable iff (reset)
        !hready |-> $onehot({pendT, pendM, pendF}))
        else $error("slave stall without a transfer in its data phase");

    aReset: assert property (@(posedge clk)
        $fell(reset) |-> !(hreadyT | hreadyM | hreadyF))
        else $error("ready output high right after reset");

endmodule

bind arbController busAssert u_busAssert (.*);

// ==== bench/tbBus.sv ====
/* Testbench for the three-master shared bus subsystem.
   Drives T, M and F transfers and checks read data, latency and grant order. */

`timescale 1ns/1ns

module tbBus;
    import busPkg::*;

    localparam int WAIT_ST = 2;
    localparam int MEM_W   = 256;
    localparam int TIMEOUT = 60;
    // Words used by all tests, all written in test 2
    localparam int REGION  = 32;

    logic              clk;
    logic              reset;
    logic              requestT;
    logic              requestM;
    logic              requestF;
    logic [ADDR_W-1:0] addrT;
    logic [ADDR_W-1:0] addrM;
    logic [ADDR_W-1:0] addrF;
    logic              writeM;
    hSize              sizeM;
    logic [DATA_W-1:0] wdataM;
    logic              hreadyT;
    logic              hreadyM;
    logic              hreadyF;
    logic [DATA_W-1:0] rdata;

    // Reference memory and per-master transfer in flight
    logic [DATA_W-1:0] refMem [MEM_W];
    logic [ADDR_W-1:0] curAddrT;
    logic [ADDR_W-1:0] curAddrM;
    logic [ADDR_W-1:0] curAddrF;
    logic              curWriteM;
    hSize              curSizeM;
    logic [DATA_W-1:0] curWdataM;

    int errors;
    int testErrors;
    int testsRun;
    int testsFailed;
    int pulseCnt [3];
    int issued [3];
    int orderQ [$];
    int seedVal;

    busTop #(
        .WAIT_STATES(WAIT_ST),
        .MEM_WORDS  (MEM_W)
    ) u_dut (
        .clk     (clk),
        .reset   (reset),
        .requestT(requestT),
        .requestM(requestM),
        .requestF(requestF),
        .addrT   (addrT),
        .addrM   (addrM),
        .addrF   (addrF),
        .writeM  (writeM),
        .sizeM   (sizeM),
        .wdataM  (wdataM),
        .hreadyT (hreadyT),
        .hreadyM (hreadyM),
        .hreadyF (hreadyF),
        .rdata   (rdata)
    );

    always #2 clk = ~clk;

    // Word index, wraps over the memory
    function automatic int wordOf(input logic [ADDR_W-1:0] addr);
        return int'((addr >> 2) % MEM_W);
    endfunction

    // Expected word after a sized write onto the old word
    function automatic logic [DATA_W-1:0] refMerge(input logic [DATA_W-1:0] old,
            input logic [DATA_W-1:0] wdata, input logic [ADDR_W-1:0] addr, input hSize size);
        logic [DATA_W-1:0] res;
        res = old;
        case (size)
            sizeByte: res[8*addr[1:0] +: 8] = wdata[8*addr[1:0] +: 8];
            sizeHalf: res[16*addr[1] +: 16] = wdata[16*addr[1] +: 16];
            default:  res = wdata;
        endcase
        return res;
    endfunction

    task automatic compareRead(input string name, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] exp;
        exp = refMem[wordOf(addr)];
        if (rdata !== exp) begin
            $display("[FAIL] %0t %s exp %h got %h", $time, name, exp, rdata);
            errors++;
        end
    endtask

    // Comparing process, one check per ready pulse
    always @(negedge clk) begin
        if (!reset) begin
            if (hreadyT) begin
                orderQ.push_back(0);
                pulseCnt[0]++;
                compareRead("rdata(T)", curAddrT);
            end
            if (hreadyM) begin
                orderQ.push_back(1);
                pulseCnt[1]++;
                if (curWriteM) begin
                    refMem[wordOf(curAddrM)] =
                        refMerge(refMem[wordOf(curAddrM)], curWdataM, curAddrM, curSizeM);
                end else begin
                    compareRead("rdata(M)", curAddrM);
                end
            end
            if (hreadyF) begin
                orderQ.push_back(2);
                pulseCnt[2]++;
                compareRead("rdata(F)", curAddrF);
            end
        end
    end

    // Counts cycles until the master's own ready pulse
    task automatic waitPulse(input int who, output int lat);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            if (who == 0) seen = hreadyT;
            else if (who == 1) seen = hreadyM;
            else seen = hreadyF;
            if (!seen) cycles++;
        end
        if (!seen) begin
            $display("Timeout: master %0d never got its ready pulse", who);
            errors++;
        end
        lat = cycles;
    endtask

    task automatic runT(input logic [ADDR_W-1:0] addr, output int lat);
        @(posedge clk);
        requestT <= 1'b1;
        addrT    <= addr;
        curAddrT = addr;
        issued[0]++;
        waitPulse(0, lat);
        @(posedge clk);
        requestT <= 1'b0;
    endtask

    task automatic runF(input logic [ADDR_W-1:0] addr, output int lat);
        @(posedge clk);
        requestF <= 1'b1;
        addrF    <= addr;
        curAddrF = addr;
        issued[2]++;
        waitPulse(2, lat);
        @(posedge clk);
        requestF <= 1'b0;
    endtask

    task automatic runM(input logic [ADDR_W-1:0] addr, input logic wr, input hSize size,
            input logic [DATA_W-1:0] wdata, output int lat);
        @(posedge clk);
        requestM <= 1'b1;
        addrM    <= addr;
        writeM   <= wr;
        sizeM    <= size;
        wdataM   <= wdata;
        curAddrM = addr;
        curWriteM = wr;
        curSizeM = size;
        curWdataM = wdata;
        issued[1]++;
        waitPulse(1, lat);
        @(posedge clk);
        requestM <= 1'b0;
        writeM   <= 1'b0;
    endtask

    // Order of the last n ready pulses
    task automatic checkOrder(input int n, input int e0, input int e1, input int e2);
        int exp [3];
        exp[0] = e0;
        exp[1] = e1;
        exp[2] = e2;
        if (orderQ.size() != n) begin
            $display("Grant order: expected %0d ready pulses, saw %0d", n, orderQ.size());
            errors++;
        end else begin
            for (int i = 0; i < n; i++) begin
                if (orderQ[i] != exp[i]) begin
                    $display("[FAIL] %0t order[%0d] exp %0d got %0d", $time, i, exp[i],
                        orderQ[i]);
                    errors++;
                end
            end
        end
        orderQ.delete();
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errors != testErrors) begin
            testsFailed++;
            $display("Test %0d %s: failed", testsRun, name);
        end else begin
            $display("Test %0d %s: passed", testsRun, name);
        end
        testErrors = errors;
    endtask

    // Random traffic from one master
    task automatic trafficT();
        int lat;
        repeat (20) begin
            repeat ($urandom_range(0, 3)) @(posedge clk);
            runT({30'($urandom_range(0, REGION - 1)), 2'b00}, lat);
        end
    endtask

    task automatic trafficF();
        int lat;
        repeat (20) begin
            repeat ($urandom_range(0, 3)) @(posedge clk);
            runF({30'($urandom_range(0, REGION - 1)), 2'b00}, lat);
        end
    endtask

    task automatic trafficM();
        int lat;
        int pick;
        hSize size;
        repeat (20) begin
            repeat ($urandom_range(0, 3)) @(posedge clk);
            pick = $urandom_range(0, 2);
            size = (pick == 0) ? sizeByte : ((pick == 1) ? sizeHalf : sizeWord);
            runM({30'($urandom_range(0, REGION - 1)), 2'($urandom_range(0, 3))
                  & ((size == sizeByte) ? 2'b11 : ((size == sizeHalf) ? 2'b10 : 2'b00))},
                 1'($urandom_range(0, 1)), size, $urandom(), lat);
        end
    endtask

    initial begin
        int lat;
        int latM;
        int latF;
        int base [3];
        clk = 1'b0;
        reset = 1'b1;
        requestT = 1'b0;
        requestM = 1'b0;
        requestF = 1'b0;
        addrT = '0;
        addrM = '0;
        addrF = '0;
        writeM = 1'b0;
        sizeM = sizeWord;
        wdataM = '0;
        errors = 0;
        testErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        seedVal = $urandom(32'h361a9644);
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // 1: idle bus after reset
        repeat (20) begin
            @(negedge clk);
            if (hreadyT | hreadyM | hreadyF) begin
                $display("[FAIL] %0t hready{T,M,F} exp 000 got %b%b%b", $time,
                    hreadyT, hreadyM, hreadyF);
                errors++;
            end
        end
        endTest("reset state");

        // 2: word writes by M, read back by T and F with fixed latency
        for (int w = 0; w < REGION; w++) begin
            runM({w[29:0], 2'b00}, 1'b1, sizeWord, $urandom(), lat);
        end
        for (int w = 0; w < REGION; w++) begin
            runT({w[29:0], 2'b00}, lat);
            if (lat != WAIT_ST + 1) begin
                $display("[FAIL] %0t latency(T) exp %0d got %0d", $time, WAIT_ST + 1, lat);
                errors++;
            end
            runF({w[29:0], 2'b00}, lat);
            if (lat != WAIT_ST + 1) begin
                $display("[FAIL] %0t latency(F) exp %0d got %0d", $time, WAIT_ST + 1, lat);
                errors++;
            end
        end
        orderQ.delete();
        endTest("single-master words");

        // 3: byte and halfword writes, then word reads
        repeat (24) begin
            int w;
            w = $urandom_range(0, REGION - 1);
            runM({w[29:0], 2'($urandom_range(0, 3))}, 1'b1, sizeByte, $urandom(), lat);
            runM({w[29:0], 1'($urandom_range(0, 1)), 1'b0}, 1'b1, sizeHalf, $urandom(), lat);
            runT({w[29:0], 2'b00}, lat);
        end
        orderQ.delete();
        endTest("sized writes");

        // 4: simultaneous requests
        fork
            runT(32'h10, lat);
            runM(32'h14, 1'b0, sizeWord, '0, latM);
            runF(32'h18, latF);
        join
        checkOrder(3, 0, 1, 2);
        fork
            runT(32'h20, lat);
            runM(32'h24, 1'b0, sizeWord, '0, latM);
        join
        checkOrder(2, 0, 1, 0);
        fork
            runT(32'h28, lat);
            runF(32'h2c, latF);
        join
        checkOrder(2, 0, 2, 0);
        fork
            runM(32'h30, 1'b0, sizeWord, '0, latM);
            runF(32'h34, latF);
        join
        checkOrder(2, 1, 2, 0);
        endTest("simultaneous requests");

        // 5: T arrives inside a running MF group
        fork
            runM(32'h38, 1'b0, sizeWord, '0, latM);
            runF(32'h3c, latF);
            begin
                repeat (2) @(posedge clk);
                runT(32'h40, lat);
            end
        join
        checkOrder(3, 1, 2, 0);
        endTest("locked sequence");

        // 6: random traffic from all masters
        for (int i = 0; i < 3; i++) begin
            base[i] = pulseCnt[i];
            issued[i] = 0;
        end
        fork
            trafficT();
            trafficM();
            trafficF();
        join
        repeat (4) @(posedge clk);
        // Exactly one ready pulse per issued request, per master
        for (int i = 0; i < 3; i++) begin
            if (pulseCnt[i] - base[i] != issued[i]) begin
                $display("[FAIL] %0t pulses(%0d) exp %0d got %0d", $time, i, issued[i],
                    pulseCnt[i] - base[i]);
                errors++;
            end
        end
        orderQ.delete();
        endTest("random traffic");

        $display("Tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rtl/busPkg.sv
rtl/waitTimer.sv
rtl/arbController.sv
rtl/busDatapath.sv
rtl/memSlave.sv
rtl/busTop.sv
bench/bus_assert.sv
bench/tbBus.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tbBus -Mdir obj_dir -o simBus
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/simBus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
